//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
verilator --binary --timing --top-module mdecode_tb -f sources.f -o mdecode_sim \
    > build.log 2>&1 \
    && ./obj_dir/mdecode_sim > sim.log 2>&1 \
    ; grep -q "^Simulation finished: PASS$" sim.log 2>/dev/null \
    && echo "Run passed" \
    || { echo "Run failed, see build.log and sim.log"; exit 1; }

//--- sim/mdecode_vectors.svh
`ifndef MDECODE_VECTORS_SVH
`define MDECODE_VECTORS_SVH

task automatic fill_table();
    // Name, instruction, size code, metadata vector, control
    add_row("sll",      32'h02A4_2080, mdecode_pkg::SIZE_5,  10'h015, 1'b0);
    add_row("srl",      32'h0364_2882, mdecode_pkg::SIZE_4,  10'h00D, 1'b0);
    add_row("jr",       32'h03E5_A408, mdecode_pkg::SIZE_10, 10'h0B4, 1'b1);
    add_row("jalr",     32'h0073_F809, mdecode_pkg::SIZE_5,  10'h013, 1'b1);
    add_row("sync",     32'h0155_000F, mdecode_pkg::SIZE_15, 10'h155, 1'b0);
    add_row("mthi",     32'h0085_A811, mdecode_pkg::SIZE_15, 10'h0B5, 1'b0);
    add_row("mult",     32'h0109_5558, mdecode_pkg::SIZE_10, 10'h155, 1'b0);
    add_row("add",      32'h0109_1FA0, mdecode_pkg::SIZE_5,  10'h01E, 1'b0);

    // NOP and SSNOP have no free bits set
    add_row("nop",      32'h0000_0000, mdecode_pkg::SIZE_13, 10'h000, 1'b0);
    add_row("ssnop",    32'h0000_0040, mdecode_pkg::SIZE_13, 10'h000, 1'b0);

    add_row("j",        32'h0810_0000, mdecode_pkg::SIZE_0,  10'h000, 1'b1);
    add_row("beq",      32'h1085_0010, mdecode_pkg::SIZE_0,  10'h000, 1'b1);
    add_row("bltz",     32'h0480_0004, mdecode_pkg::SIZE_0,  10'h000, 1'b1);
    add_row("bgezal",   32'h0491_0004, mdecode_pkg::SIZE_0,  10'h000, 1'b1);
    add_row("blezl",    32'h58A3_0010, mdecode_pkg::SIZE_5,  10'h003, 1'b1);
    add_row("lui",      32'h3D48_1234, mdecode_pkg::SIZE_5,  10'h00A, 1'b0);
    add_row("synci",    32'h049F_0040, mdecode_pkg::SIZE_15, 10'h09F, 1'b0);
    add_row("tgei",     32'h0488_0005, mdecode_pkg::SIZE_0,  10'h000, 1'b0);

    add_row("madd",     32'h7085_D400, mdecode_pkg::SIZE_5,  10'h01A, 1'b0);
    add_row("msub",     32'h7085_A9C4, mdecode_pkg::SIZE_10, 10'h2A7, 1'b0);
    add_row("clz",      32'h7082_1520, mdecode_pkg::SIZE_5,  10'h014, 1'b0);
    add_row("seb",      32'h7E65_1420, mdecode_pkg::SIZE_5,  10'h013, 1'b0);
    add_row("seh",      32'h7D25_1620, mdecode_pkg::SIZE_5,  10'h009, 1'b0);
    add_row("wsbh",     32'h7C05_10A0, mdecode_pkg::SIZE_0,  10'h000, 1'b0); // BSHFL, other sa
    add_row("rdhwr",    32'h7C03_E93B, mdecode_pkg::SIZE_5,  10'h004, 1'b0);
    add_row("prefx",    32'h4C85_0B4F, mdecode_pkg::SIZE_5,  10'h00D, 1'b0);

    add_row("lw",       32'h8FA4_0010, mdecode_pkg::SIZE_0,  10'h000, 1'b0);
    add_row("sw",       32'hAFBF_0014, mdecode_pkg::SIZE_0,  10'h000, 1'b0);
    add_row("spec_rsv", 32'h0123_4005, mdecode_pkg::SIZE_0,  10'h000, 1'b0);
    add_row("sp2_rsv",  32'h7000_0010, mdecode_pkg::SIZE_0,  10'h000, 1'b0);
    add_row("op_rsv",   32'hEC00_0000, mdecode_pkg::SIZE_0,  10'h000, 1'b0);
endtask

`endif

//--- sim/mdecode_tb.sv
`timescale 1ns/10ps
`include "mdecode_params.svh"

module mdecode_tb;

    localparam int RESET_CYCLES = 5;
    localparam int LATENCY      = 2;        // Drive cycle to the negedge after edge N+2

    logic                  clk = 1'b0;
    logic                  reset;
    logic [`MD_INST_W-1:0] inst;
    logic                  inst_valid;
    logic [`MD_SIZE_W-1:0] metadata_size;
    logic [`MD_VEC_W-1:0]  metadata_vector;
    logic                  is_control;
    logic                  md_valid;

    // Stimulus table, filled from the vectors file
    string                  row_name[$];
    logic [`MD_INST_W-1:0]  row_inst[$];
    mdecode_pkg::md_size_e  row_size[$];
    logic [`MD_VEC_W-1:0]   row_vec[$];
    logic                   row_ctrl[$];

    // Items in flight
    string                  exp_name[$];
    mdecode_pkg::md_size_e  exp_size[$];
    logic [`MD_VEC_W-1:0]   exp_vec[$];
    logic                   exp_ctrl[$];
    int                     exp_due[$];

    int   cycle_count    = 0;
    int   timeout_limit  = 1000;
    int   mismatch_count = 0;
    int   other_count    = 0;
    logic seen_output    = 1'b0;

    mdecode_top u_dut (
        .clk(clk), .reset(reset), .inst(inst), .inst_valid(inst_valid),
        .metadata_size(metadata_size), .metadata_vector(metadata_vector),
        .is_control(is_control), .md_valid(md_valid)
    );

    always #10 clk = ~clk;

    task automatic add_row(input string name, input logic [`MD_INST_W-1:0] i,
                           input mdecode_pkg::md_size_e s, input logic [`MD_VEC_W-1:0] v,
                           input logic c);
        row_name.push_back(name);
        row_inst.push_back(i);
        row_size.push_back(s);
        row_vec.push_back(v);
        row_ctrl.push_back(c);
    endtask

    `include "mdecode_vectors.svh"

    task automatic check_size(input string name, input mdecode_pkg::md_size_e exp,
                              input logic [`MD_SIZE_W-1:0] act);
        logic [`MD_SIZE_W-1:0] exp_w;
        exp_w = exp;                        // Zero-extended size code
        if (act !== exp_w) begin
            $display("MISMATCH %s size: expected %0d, actual %0d", name, exp_w, act);
            mismatch_count++;
        end
    endtask

    task automatic check_vector(input string name, input logic [`MD_VEC_W-1:0] exp,
                                input logic [`MD_VEC_W-1:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s vector: expected 0x%03h, actual 0x%03h", name, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic check_control(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s control: expected %b, actual %b", name, exp, act);
            mismatch_count++;
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_limit) begin
            $display("Timeout at cycle %0d, outputs stopped arriving", cycle_count);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // Outputs are read mid-cycle
    always @(negedge clk) begin
        if (cycle_count >= 1) begin
            if (md_valid === 1'b1) begin
                seen_output = 1'b1;
                if (exp_name.size() == 0) begin
                    $display("Output valid at cycle %0d with no instruction pending", cycle_count);
                    other_count++;
                end else begin
                    if (cycle_count != exp_due[0]) begin
                        $display("Row %s came out at cycle %0d instead of cycle %0d",
                                 exp_name[0], cycle_count, exp_due[0]);
                        other_count++;
                    end
                    check_size(exp_name[0], exp_size[0], metadata_size);
                    check_vector(exp_name[0], exp_vec[0], metadata_vector);
                    check_control(exp_name[0], exp_ctrl[0], is_control);
                    void'(exp_name.pop_front());
                    void'(exp_size.pop_front());
                    void'(exp_vec.pop_front());
                    void'(exp_ctrl.pop_front());
                    void'(exp_due.pop_front());
                end
            end else begin
                if (md_valid !== 1'b0) begin
                    $display("md_valid is unknown at cycle %0d", cycle_count);
                    other_count++;
                end
                if (!seen_output && (metadata_size !== '0 || metadata_vector !== '0 ||
                                     is_control !== 1'b0)) begin
                    $display("Outputs not zero before the first result, cycle %0d", cycle_count);
                    other_count++;
                end
                if (exp_due.size() > 0 && cycle_count >= exp_due[0]) begin
                    $display("No output for row %s by cycle %0d", exp_name[0], cycle_count);
                    other_count++;
                    void'(exp_name.pop_front());
                    void'(exp_size.pop_front());
                    void'(exp_vec.pop_front());
                    void'(exp_ctrl.pop_front());
                    void'(exp_due.pop_front());
                end
            end
        end
    end

    initial begin
        reset      = 1'b1;
        inst       = '0;
        inst_valid = 1'b0;
        fill_table();
        timeout_limit = row_name.size() + RESET_CYCLES + 20;

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;

        // One row per cycle, back to back
        for (int i = 0; i < row_name.size(); i++) begin
            inst       = row_inst[i];
            inst_valid = 1'b1;
            exp_name.push_back(row_name[i]);
            exp_size.push_back(row_size[i]);
            exp_vec.push_back(row_vec[i]);
            exp_ctrl.push_back(row_ctrl[i]);
            exp_due.push_back(cycle_count + LATENCY);
            @(posedge clk);
            #2;
        end
        inst_valid = 1'b0;
        inst       = '0;

        while (exp_name.size() != 0) @(posedge clk);
        repeat (3) @(negedge clk);  // Catch stray valid outputs

        $display("Error summary: %0d mismatches, %0d other errors", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- source/major_decode.sv
`timescale 1ns/10ps
`include "mdecode_params.svh"

module major_decode (
    input  logic [`MD_INST_W-1:0]  inst,
    output logic                   claim,
    output mdecode_pkg::md_size_e  size,
    output mdecode_pkg::md_field_e field,
    output logic                   control
);

    // Opcodes owned by the function-field decoder
    localparam logic [5:0] OP_SPECIAL  = 6'h00;
    localparam logic [5:0] OP_COP1X    = 6'h13;
    localparam logic [5:0] OP_SPECIAL2 = 6'h1c;
    localparam logic [5:0] OP_SPECIAL3 = 6'h1f;

    localparam logic [5:0] OP_REGIMM   = 6'h01;
    localparam logic [5:0] OP_LUI      = 6'h0f;
    localparam logic [4:0] RT_SYNCI    = 5'h1f;

    logic [5:0] opcode;
    logic [4:0] rt;

    assign opcode = inst[`MD_OPCODE_HI:`MD_OPCODE_LO];
    assign rt     = inst[`MD_RT_HI:`MD_RT_LO];

    assign claim = !(opcode == OP_SPECIAL || opcode == OP_COP1X ||
                     opcode == OP_SPECIAL2 || opcode == OP_SPECIAL3);

    always_comb begin
        size    = mdecode_pkg::SIZE_0;
        field   = mdecode_pkg::FIELD_NONE;
        control = 1'b0;

        case (opcode)
            OP_REGIMM: begin
                case (rt)
                    5'h00, 5'h01, 5'h02, 5'h03: begin // BLTZ, BGEZ and likely forms
                        control = 1'b1;
                    end
                    5'h10, 5'h11, 5'h12, 5'h13: begin // And-link forms
                        control = 1'b1;
                    end
                    RT_SYNCI: begin
                        size  = mdecode_pkg::SIZE_15;
                        field = mdecode_pkg::FIELD_B25;
                    end
                    default: ;  // Traps and reserved
                endcase
            end

            6'h02, 6'h03, 6'h04, 6'h05: begin // J, JAL, BEQ, BNE
                control = 1'b1;
            end

            6'h14, 6'h15, 6'h1d: begin // BEQL, BNEL, JALX
                control = 1'b1;
            end

            6'h06, 6'h07: begin // BLEZ, BGTZ
                size  = mdecode_pkg::SIZE_5;
                field = mdecode_pkg::FIELD_B20;
            end

            6'h16, 6'h17: begin // BLEZL, BGTZL
                size    = mdecode_pkg::SIZE_5;
                field   = mdecode_pkg::FIELD_B20;
                control = 1'b1;
            end

            OP_LUI: begin
                size  = mdecode_pkg::SIZE_5;
                field = mdecode_pkg::FIELD_B25;
            end

            default: ;  // Immediates, loads, stores, coprocessor ops
        endcase
    end

endmodule

//--- source/mdecode_params.svh
`ifndef MDECODE_PARAMS_SVH
`define MDECODE_PARAMS_SVH

`define MD_INST_W       32
`define MD_VEC_W        10
`define MD_SIZE_W       5           // Width of the size code at the top level

// Instruction field bounds
`define MD_OPCODE_HI    31
`define MD_OPCODE_LO    26
`define MD_RT_HI        20
`define MD_RT_LO        16
`define MD_SA_HI        10
`define MD_SA_LO        6
`define MD_FUNC_HI      5
`define MD_FUNC_LO      0

// Start bits of the metadata slices
`define MD_START_B25    25
`define MD_START_B20    20
`define MD_START_B15    15
`define MD_START_B10    10

// NOP vector is bits 22..16 followed by 10..8
`define MD_NOP_A_HI     22
`define MD_NOP_A_LO     16
`define MD_NOP_B_HI     10
`define MD_NOP_B_LO     8

// Slice lengths shorter than the vector
`define MD_LEN_SIZE_5   5
`define MD_LEN_SIZE_4   4

`endif

//--- source/mdecode_pkg.sv
package mdecode_pkg;

    // Size codes, values fixed by the consumer
    typedef enum logic [2:0] {
        SIZE_0  = 3'd0,
        SIZE_5  = 3'd1,
        SIZE_4  = 3'd2,
        SIZE_10 = 3'd3,
        SIZE_15 = 3'd4,
        SIZE_13 = 3'd5,
        SIZE_19 = 3'd6      // Reserved code, no entry produces it
    } md_size_e;

    // Where the metadata bits are taken from
    typedef enum logic [2:0] {
        FIELD_NONE = 3'd0,  // Zero vector
        FIELD_B25  = 3'd1,
        FIELD_B20  = 3'd2,
        FIELD_B15  = 3'd3,
        FIELD_B10  = 3'd4,
        FIELD_NOP  = 3'd5   // Split field of NOP and SSNOP
    } md_field_e;

endpackage

//--- source/mdecode_top.sv
`timescale 1ns/10ps
`include "mdecode_params.svh"

module mdecode_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`MD_INST_W-1:0]  inst,
    input  logic                   inst_valid,
    output logic [`MD_SIZE_W-1:0]  metadata_size,
    output logic [`MD_VEC_W-1:0]   metadata_vector,
    output logic                   is_control,
    output logic                   md_valid
);

    logic [`MD_INST_W-1:0]  inst_q;
    logic                   inst_valid_q;

    logic                   sp_claim;
    mdecode_pkg::md_size_e  sp_size;
    mdecode_pkg::md_field_e sp_field;
    logic                   sp_control;
    logic                   mj_claim;
    mdecode_pkg::md_size_e  mj_size;
    mdecode_pkg::md_field_e mj_field;
    logic                   mj_control;

    mdecode_pkg::md_size_e  ext_size;
    logic [`MD_VEC_W-1:0]   ext_vector;
    logic                   ext_control;

    // Input stage
    always_ff @(posedge clk) begin
        if (reset) begin
            inst_valid_q <= 1'b0;
        end else begin
            inst_valid_q <= inst_valid;
        end
        if (inst_valid) begin
            inst_q <= inst;
        end
    end

    special_decode u_special (.inst(inst_q), .claim(sp_claim), .size(sp_size),
                              .field(sp_field), .control(sp_control));

    major_decode u_major (.inst(inst_q), .claim(mj_claim), .size(mj_size),
                          .field(mj_field), .control(mj_control));

    metadata_extract u_extract (
        .inst(inst_q),
        .special_claim(sp_claim), .special_size(sp_size),
        .special_field(sp_field), .special_control(sp_control),
        .major_claim(mj_claim), .major_size(mj_size),
        .major_field(mj_field), .major_control(mj_control),
        .size(ext_size), .vector(ext_vector), .control(ext_control)
    );

    // Output stage holds the last result between valid items
    always_ff @(posedge clk) begin
        if (reset) begin
            metadata_size   <= '0;
            metadata_vector <= '0;
            is_control      <= 1'b0;
            md_valid        <= 1'b0;
        end else begin
            md_valid <= inst_valid_q;
            if (inst_valid_q) begin
                metadata_size   <= {{(`MD_SIZE_W - $bits(ext_size)){1'b0}}, ext_size};
                metadata_vector <= ext_vector;
                is_control      <= ext_control;
            end
        end
    end

endmodule

//--- source/metadata_extract.sv
`timescale 1ns/10ps
`include "mdecode_params.svh"

module metadata_extract (
    input  logic [`MD_INST_W-1:0]  inst,
    input  logic                   special_claim,
    input  mdecode_pkg::md_size_e  special_size,
    input  mdecode_pkg::md_field_e special_field,
    input  logic                   special_control,
    input  logic                   major_claim,
    input  mdecode_pkg::md_size_e  major_size,
    input  mdecode_pkg::md_field_e major_field,
    input  logic                   major_control,
    output mdecode_pkg::md_size_e  size,
    output logic [`MD_VEC_W-1:0]   vector,
    output logic                   control
);

    mdecode_pkg::md_field_e sel_field;
    logic [`MD_VEC_W-1:0]   window;

    always_comb begin
        if (special_claim) begin
            size      = special_size;
            sel_field = special_field;
            control   = special_control;
        end else if (major_claim) begin
            size      = major_size;
            sel_field = major_field;
            control   = major_control;
        end else begin
            size      = mdecode_pkg::SIZE_0;
            sel_field = mdecode_pkg::FIELD_NONE;
            control   = 1'b0;
        end
    end

    // Top-aligned 10-bit window from the start bit
    always_comb begin
        case (sel_field)
            mdecode_pkg::FIELD_B25: window = inst[`MD_START_B25 -: `MD_VEC_W];
            mdecode_pkg::FIELD_B20: window = inst[`MD_START_B20 -: `MD_VEC_W];
            mdecode_pkg::FIELD_B15: window = inst[`MD_START_B15 -: `MD_VEC_W];
            mdecode_pkg::FIELD_B10: window = inst[`MD_START_B10 -: `MD_VEC_W];
            mdecode_pkg::FIELD_NOP: window = {inst[`MD_NOP_A_HI:`MD_NOP_A_LO],
                                              inst[`MD_NOP_B_HI:`MD_NOP_B_LO]};
            default:                window = '0;
        endcase
    end

    // Short slices end above the window, so drop their lower bits
    always_comb begin
        case (size)
            mdecode_pkg::SIZE_5: vector = window >> (`MD_VEC_W - `MD_LEN_SIZE_5);
            mdecode_pkg::SIZE_4: vector = window >> (`MD_VEC_W - `MD_LEN_SIZE_4);
            default:             vector = window;
        endcase
    end

endmodule

//--- source/special_decode.sv
`timescale 1ns/10ps
`include "mdecode_params.svh"

module special_decode (
    input  logic [`MD_INST_W-1:0]  inst,
    output logic                   claim,
    output mdecode_pkg::md_size_e  size,
    output mdecode_pkg::md_field_e field,
    output logic                   control
);

    localparam logic [5:0] OP_SPECIAL  = 6'h00;
    localparam logic [5:0] OP_COP1X    = 6'h13;
    localparam logic [5:0] OP_SPECIAL2 = 6'h1c;
    localparam logic [5:0] OP_SPECIAL3 = 6'h1f;

    localparam logic [5:0] FN_BSHFL    = 6'h20;
    localparam logic [5:0] FN_RDHWR    = 6'h3b;
    localparam logic [5:0] FN_PREFX    = 6'h0f;
    localparam logic [4:0] SA_SEB      = 5'b10000;
    localparam logic [4:0] SA_SEH      = 5'b11000;

    localparam logic [`MD_INST_W-1:0] INST_NOP   = 32'h0000_0000;
    localparam logic [`MD_INST_W-1:0] INST_SSNOP = 32'h0000_0040;

    logic [5:0] opcode;
    logic [5:0] func;
    logic [4:0] sa;

    assign opcode = inst[`MD_OPCODE_HI:`MD_OPCODE_LO];
    assign func   = inst[`MD_FUNC_HI:`MD_FUNC_LO];
    assign sa     = inst[`MD_SA_HI:`MD_SA_LO];

    assign claim = (opcode == OP_SPECIAL) || (opcode == OP_COP1X) ||
                   (opcode == OP_SPECIAL2) || (opcode == OP_SPECIAL3);

    always_comb begin
        size    = mdecode_pkg::SIZE_0;
        field   = mdecode_pkg::FIELD_NONE;
        control = 1'b0;

        case (opcode)
            OP_SPECIAL: begin
                case (func)
                    6'h00, 6'h03, 6'h38, 6'h3a, 6'h3b, 6'h3c, 6'h3e, 6'h3f: begin // Shifts by sa
                        size  = mdecode_pkg::SIZE_5;
                        field = mdecode_pkg::FIELD_B25;
                    end
                    6'h02: begin // SRL
                        size  = mdecode_pkg::SIZE_4;
                        field = mdecode_pkg::FIELD_B25;
                    end
                    6'h04, 6'h07, 6'h0a, 6'h0b, 6'h10, 6'h12, 6'h14, 6'h16, 6'h17: begin
                        size  = mdecode_pkg::SIZE_5;
                        field = mdecode_pkg::FIELD_B10;
                    end
                    6'h06: begin // SRLV
                        size  = mdecode_pkg::SIZE_4;
                        field = mdecode_pkg::FIELD_B10;
                    end
                    6'h08: begin // JR
                        size    = mdecode_pkg::SIZE_10;
                        field   = mdecode_pkg::FIELD_B20;
                        control = 1'b1;
                    end
                    6'h09: begin // JALR
                        size    = mdecode_pkg::SIZE_5;
                        field   = mdecode_pkg::FIELD_B20;
                        control = 1'b1;
                    end
                    6'h0f: begin // SYNC
                        size  = mdecode_pkg::SIZE_15;
                        field = mdecode_pkg::FIELD_B25;
                    end
                    6'h11, 6'h13: begin // MTHI, MTLO
                        size  = mdecode_pkg::SIZE_15;
                        field = mdecode_pkg::FIELD_B20;
                    end
                    6'h18, 6'h19, 6'h1a, 6'h1b, 6'h1c, 6'h1d, 6'h1e, 6'h1f: begin // Mul and div
                        size  = mdecode_pkg::SIZE_10;
                        field = mdecode_pkg::FIELD_B15;
                    end
                    6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27,
                    6'h2a, 6'h2b, 6'h2c, 6'h2d, 6'h2e, 6'h2f: begin // Three-register ALU ops
                        size  = mdecode_pkg::SIZE_5;
                        field = mdecode_pkg::FIELD_B10;
                    end
                    default: ;
                endcase
            end

            OP_SPECIAL2: begin
                case (func)
                    6'h00: begin // MADD
                        size  = mdecode_pkg::SIZE_5;
                        field = mdecode_pkg::FIELD_B15;
                    end
                    6'h01, 6'h04, 6'h05: begin // MADDU, MSUB, MSUBU
                        size  = mdecode_pkg::SIZE_10;
                        field = mdecode_pkg::FIELD_B15;
                    end
                    6'h02, 6'h20, 6'h21: begin // MUL, CLZ, CLO
                        size  = mdecode_pkg::SIZE_5;
                        field = mdecode_pkg::FIELD_B10;
                    end
                    default: ;
                endcase
            end

            OP_SPECIAL3: begin
                if (func == FN_BSHFL && (sa == SA_SEB || sa == SA_SEH)) begin
                    size  = mdecode_pkg::SIZE_5;
                    field = mdecode_pkg::FIELD_B25;
                end else if (func == FN_RDHWR) begin
                    size  = mdecode_pkg::SIZE_5;
                    field = mdecode_pkg::FIELD_B10;
                end
            end

            OP_COP1X: begin
                if (func == FN_PREFX) begin
                    size  = mdecode_pkg::SIZE_5;
                    field = mdecode_pkg::FIELD_B10;
                end
            end

            default: ;
        endcase

        // NOP and SSNOP carry the wider split field
        if (inst == INST_NOP || inst == INST_SSNOP) begin
            size  = mdecode_pkg::SIZE_13;
            field = mdecode_pkg::FIELD_NOP;
        end
    end

endmodule

//--- sources.f
+incdir+source
+incdir+sim
source/mdecode_pkg.sv
source/special_decode.sv
source/major_decode.sv
source/metadata_extract.sv
source/mdecode_top.sv
sim/mdecode_tb.sv
